// File: src/sensor_channel_cfg.svh
`ifndef SENSOR_CHANNEL_CFG_SVH
`define SENSOR_CHANNEL_CFG_SVH

// register map of the channel
`define SENS_BASE_ADDR           16'h0400  // channel register base
`define SENS_CTRL_RADDR          0         // mode register
`define SENS_SYNC_MULT_RADDR     2         // frames to combine minus 1
`define SENS_GAMMA_RADDR         'h39      // gamma table address/data

// mode register bits
`define SENS_MODE_EN_BIT         0         // channel enable
`define SENS_MODE_16BIT_BIT      1         // 1 - bypass gamma, 16 bit out

// gamma address/data word
`define SENS_GAMMA_ADDR_FLAG_BIT 20        // set - word loads table address

// widths
`define SENS_PXD_WIDTH           12        // sensor pixel
`define SENS_CMD_BYTES           6         // AL, AH, D0..D3
`define SENS_SYNC_MULT_WIDTH     8         // frame decimation count

`endif

// File: src/sensor_cmd_pkg.sv
`include "sensor_channel_cfg.svh"

package sensor_cmd_pkg;

    typedef logic [7:0]  cmd_byte_t;  // one byte of the serial command
    typedef logic [15:0] cmd_addr_t;  // register address, AL first
    typedef logic [31:0] cmd_data_t;  // register data, D0 in the low byte

    // command deserializer
    typedef enum logic {
        CMD_IDLE, // waiting for strobe
        CMD_RECV  // collecting remaining bytes
    } cmd_state_e;

    typedef logic [`SENS_SYNC_MULT_WIDTH-1:0] sync_mult_t; // frames minus 1

endpackage

// File: src/sensor_pix_pkg.sv
`include "sensor_channel_cfg.svh"

package sensor_pix_pkg;

    typedef logic [`SENS_PXD_WIDTH-1:0] pxd_t; // raw sensor pixel

    // gamma table
    typedef logic [7:0] gamma_idx_t;  // top bits of the pixel
    typedef logic [7:0] gamma_val_t;  // 8 bit output pixel

    // output word, two 8 bit pixels or one msb-aligned pixel
    typedef logic [15:0] dout_t;

endpackage

// File: src/cmd_decoder.sv
`timescale 1ns/1ps
`include "sensor_channel_cfg.svh"

module cmd_decoder (
    input  logic                       mclk,
    input  logic                       mrst,
    input  sensor_cmd_pkg::cmd_byte_t  cmd_ad_i,      // AL, AH, D0..D3
    input  logic                       cmd_stb_i,     // marks AL
    output logic                       en_o,          // channel enable
    output logic                       bit16_o,       // 16 bit bypass
    output logic                       mult_we_o,     // pulse with new mult
    output sensor_cmd_pkg::sync_mult_t mult_o,
    output logic                       gamma_we_o,    // gamma addr/data write
    output sensor_cmd_pkg::cmd_data_t  gamma_wdata_o
);
    localparam sensor_cmd_pkg::cmd_addr_t CTRL_ADDR =
        sensor_cmd_pkg::cmd_addr_t'(`SENS_BASE_ADDR + `SENS_CTRL_RADDR);
    localparam sensor_cmd_pkg::cmd_addr_t MULT_ADDR =
        sensor_cmd_pkg::cmd_addr_t'(`SENS_BASE_ADDR + `SENS_SYNC_MULT_RADDR);
    localparam sensor_cmd_pkg::cmd_addr_t GAMMA_ADDR =
        sensor_cmd_pkg::cmd_addr_t'(`SENS_BASE_ADDR + `SENS_GAMMA_RADDR);
    localparam logic [2:0] LAST_BYTE = 3'(`SENS_CMD_BYTES - 1);

    sensor_cmd_pkg::cmd_state_e state;
    logic [2:0]                 byte_cnt;  // index of the byte on the bus
    sensor_cmd_pkg::cmd_addr_t  addr;
    sensor_cmd_pkg::cmd_data_t  data;
    logic                       full;      // all bytes in, decode now
    logic                       ctrl_hit;
    logic                       mult_hit;
    logic                       gamma_hit;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state    <= sensor_cmd_pkg::CMD_IDLE;
            byte_cnt <= '0;
            full     <= 1'b0;
        end else begin
            full <= 1'b0;
            if (cmd_stb_i) begin                       // restart on any strobe
                state    <= sensor_cmd_pkg::CMD_RECV;
                byte_cnt <= 3'd1;
            end else if (state == sensor_cmd_pkg::CMD_RECV) begin
                byte_cnt <= byte_cnt + 3'd1;
                if (byte_cnt == LAST_BYTE) begin       // sixth byte on the bus
                    state <= sensor_cmd_pkg::CMD_IDLE;
                    full  <= 1'b1;
                end
            end
        end
    end

    // shift bytes in, low byte first
    always_ff @(posedge mclk) begin
        if (cmd_stb_i || (state == sensor_cmd_pkg::CMD_RECV && byte_cnt == 3'd1))
            addr <= {cmd_ad_i, addr[15:8]};            // AL then AH
        else if (state == sensor_cmd_pkg::CMD_RECV)
            data <= {cmd_ad_i, data[31:8]};            // D0 ends up in [7:0]
    end

    assign ctrl_hit  = full && (addr == CTRL_ADDR);
    assign mult_hit  = full && (addr == MULT_ADDR);
    assign gamma_hit = full && (addr == GAMMA_ADDR);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            en_o       <= 1'b0;
            bit16_o    <= 1'b0;
            mult_o     <= '0;
            mult_we_o  <= 1'b0;
            gamma_we_o <= 1'b0;
        end else begin
            mult_we_o  <= mult_hit;                    // one pulse per command
            gamma_we_o <= gamma_hit;
            if (ctrl_hit) begin                        // mode register
                en_o    <= data[`SENS_MODE_EN_BIT];
                bit16_o <= data[`SENS_MODE_16BIT_BIT];
            end
            if (mult_hit)
                mult_o <= data[$bits(sensor_cmd_pkg::sync_mult_t)-1:0];
        end
    end

    assign gamma_wdata_o = data; // stable while gamma_we_o is high

endmodule

// File: src/frame_sync.sv
`timescale 1ns/1ps

module frame_sync (
    input  logic                       mclk,
    input  logic                       mrst,
    input  logic                       en_i,       // channel enable
    input  logic                       mult_we_i,  // mult just written
    input  sensor_cmd_pkg::sync_mult_t mult_i,     // frames to combine minus 1
    input  sensor_pix_pkg::pxd_t       pxd_i,
    input  logic                       hact_i,     // line active level
    input  logic                       sof_i,      // start of frame pulse
    input  logic                       eof_i,      // end of frame pulse
    output sensor_pix_pkg::pxd_t       pxd_o,
    output logic                       hact_o,
    output logic                       sof_o,      // decimated sof
    output logic                       eof_o,
    output logic                       sof_mclk_o  // same pulse as sof_o
);
    sensor_cmd_pkg::sync_mult_t frame_cnt; // frames since last passed sof
    logic                       sof_pass;

    assign sof_pass = sof_i && en_i && (frame_cnt == '0);

    always_ff @(posedge mclk) begin
        if (mrst || mult_we_i || !en_i)
            frame_cnt <= '0;                        // next sof goes through
        else if (sof_i)
            frame_cnt <= (frame_cnt == mult_i) ? '0 : frame_cnt + 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            hact_o <= 1'b0;
            sof_o  <= 1'b0;
            eof_o  <= 1'b0;
        end else begin
            hact_o <= hact_i && en_i;               // gated by enable
            sof_o  <= sof_pass;
            eof_o  <= eof_i && en_i;                // every enabled frame
        end
    end

    always_ff @(posedge mclk) begin
        pxd_o <= pxd_i;                             // aligned with hact_o
    end

    assign sof_mclk_o = sof_o;

endmodule

// File: src/gamma_lut.sv
`timescale 1ns/1ps
`include "sensor_channel_cfg.svh"

module gamma_lut (
    input  logic                      mclk,
    input  logic                      mrst,
    input  logic                      we_i,      // address/data write
    input  sensor_cmd_pkg::cmd_data_t wdata_i,
    input  sensor_pix_pkg::pxd_t      pxd_i,
    input  logic                      hact_i,
    input  logic                      sof_i,
    input  logic                      eof_i,
    output sensor_pix_pkg::gamma_val_t g_pxd_o,  // table output
    output logic                      g_hact_o,
    output logic                      g_sof_o,
    output logic                      g_eof_o
);
    localparam int IDX_W = $bits(sensor_pix_pkg::gamma_idx_t);
    localparam int VAL_W = $bits(sensor_pix_pkg::gamma_val_t);

    sensor_pix_pkg::gamma_val_t table_mem [0:(1 << IDX_W)-1];
    sensor_pix_pkg::gamma_idx_t waddr;   // table write pointer
    sensor_pix_pkg::gamma_idx_t ridx;    // stage 1 read index
    logic                       hact_d;  // stage 1 strobes
    logic                       sof_d;
    logic                       eof_d;

    always_ff @(posedge mclk) begin
        if (mrst)
            waddr <= '0;
        else if (we_i) begin
            if (wdata_i[`SENS_GAMMA_ADDR_FLAG_BIT])
                waddr <= wdata_i[IDX_W-1:0];       // set table address
            else
                waddr <= waddr + 1'b1;             // auto increment on data
        end
    end

    always_ff @(posedge mclk) begin
        if (we_i && !wdata_i[`SENS_GAMMA_ADDR_FLAG_BIT])
            table_mem[waddr] <= wdata_i[VAL_W-1:0];
    end

    // two stage read, index then table
    always_ff @(posedge mclk) begin
        ridx    <= pxd_i[$bits(sensor_pix_pkg::pxd_t)-1 -: IDX_W]; // top 8 bits
        g_pxd_o <= table_mem[ridx];
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            {hact_d, sof_d, eof_d}       <= '0;
            {g_hact_o, g_sof_o, g_eof_o} <= '0;
        end else begin
            {hact_d, sof_d, eof_d}       <= {hact_i, sof_i, eof_i};
            {g_hact_o, g_sof_o, g_eof_o} <= {hact_d, sof_d, eof_d}; // match read
        end
    end

endmodule

// File: src/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
    input  logic                       mclk,
    input  logic                       mrst,
    input  logic                       bit16_i,      // 1 - bypass path
    input  sensor_pix_pkg::pxd_t       pxd_i,        // bypass pixel
    input  logic                       hact_i,
    input  logic                       sof_i,
    input  logic                       eof_i,
    input  sensor_pix_pkg::gamma_val_t g_pxd_i,      // gamma pixel
    input  logic                       g_hact_i,
    input  logic                       g_sof_i,
    input  logic                       g_eof_i,
    output sensor_pix_pkg::dout_t      dout_o,
    output logic                       dout_valid_o,
    output logic                       sof_o,
    output logic                       eof_o
);
    localparam int PAD_W = $bits(sensor_pix_pkg::dout_t) - $bits(sensor_pix_pkg::pxd_t);

    logic                       phase;    // 1 - second pixel of a pair
    sensor_pix_pkg::gamma_val_t lo_byte;  // earlier pixel of the pair

    always_ff @(posedge mclk) begin
        if (mrst)
            phase <= 1'b0;
        else
            phase <= g_hact_i && !phase;          // clears between lines
    end

    always_ff @(posedge mclk) begin
        if (g_hact_i && !phase)
            lo_byte <= g_pxd_i;
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            dout_o       <= '0;
            dout_valid_o <= 1'b0;
            sof_o        <= 1'b0;
            eof_o        <= 1'b0;
        end else begin
            dout_valid_o <= bit16_i ? hact_i : (g_hact_i && phase);
            sof_o        <= bit16_i ? sof_i : g_sof_i;  // follow the data path
            eof_o        <= bit16_i ? eof_i : g_eof_i;
            if (bit16_i && hact_i)
                dout_o <= {pxd_i, {PAD_W{1'b0}}};       // msb aligned
            else if (!bit16_i && g_hact_i && phase)
                dout_o <= {g_pxd_i, lo_byte};           // earlier pixel in lsb
        end
    end

endmodule

// File: src/sensor_channel.sv
`timescale 1ns/1ps

module sensor_channel (
    input  logic                      mclk,
    input  logic                      mrst,         // sync, active high
    input  sensor_cmd_pkg::cmd_byte_t cmd_ad_i,     // byte-serial command
    input  logic                      cmd_stb_i,    // with first byte
    input  sensor_pix_pkg::pxd_t      pxd_i,
    input  logic                      hact_i,       // line active level
    input  logic                      sof_i,        // frame start pulse
    input  logic                      eof_i,        // frame end pulse
    output sensor_pix_pkg::dout_t     dout_o,
    output logic                      dout_valid_o,
    output logic                      sof_o,        // aligned with dout_o
    output logic                      eof_o,
    output logic                      sof_mclk_o    // decimated sof, 1 cycle
);
    logic                       en;
    logic                       bit16;
    logic                       mult_we;
    sensor_cmd_pkg::sync_mult_t mult;
    logic                       gamma_we;
    sensor_cmd_pkg::cmd_data_t  gamma_wdata;

    // registered and gated pixel stream
    sensor_pix_pkg::pxd_t       pxd;
    logic                       hact;
    logic                       sof;
    logic                       eof;

    // gamma output stream
    sensor_pix_pkg::gamma_val_t g_pxd;
    logic                       g_hact;
    logic                       g_sof;
    logic                       g_eof;

    cmd_decoder u_cmd_decoder (
        .mclk(mclk), .mrst(mrst), .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .en_o(en), .bit16_o(bit16), .mult_we_o(mult_we), .mult_o(mult),
        .gamma_we_o(gamma_we), .gamma_wdata_o(gamma_wdata)
    );

    frame_sync u_frame_sync (
        .mclk(mclk), .mrst(mrst), .en_i(en), .mult_we_i(mult_we), .mult_i(mult),
        .pxd_i(pxd_i), .hact_i(hact_i), .sof_i(sof_i), .eof_i(eof_i),
        .pxd_o(pxd), .hact_o(hact), .sof_o(sof), .eof_o(eof), .sof_mclk_o(sof_mclk_o)
    );

    gamma_lut u_gamma_lut (
        .mclk(mclk), .mrst(mrst), .we_i(gamma_we), .wdata_i(gamma_wdata),
        .pxd_i(pxd), .hact_i(hact), .sof_i(sof), .eof_i(eof),
        .g_pxd_o(g_pxd), .g_hact_o(g_hact), .g_sof_o(g_sof), .g_eof_o(g_eof)
    );

    pixel_packer u_pixel_packer (
        .mclk(mclk), .mrst(mrst), .bit16_i(bit16),
        .pxd_i(pxd), .hact_i(hact), .sof_i(sof), .eof_i(eof),
        .g_pxd_i(g_pxd), .g_hact_i(g_hact), .g_sof_i(g_sof), .g_eof_i(g_eof),
        .dout_o(dout_o), .dout_valid_o(dout_valid_o), .sof_o(sof_o), .eof_o(eof_o)
    );

endmodule

// File: testbench/tb_sensor_channel.sv
`timescale 1ns/1ps
`include "sensor_channel_cfg.svh"

module tb_sensor_channel;
    localparam int NROWS   = 9;
    localparam int CMD_CYC = 7;                          // six bytes plus write cycle
    localparam logic [15:0] CTRL_REG  = 16'(`SENS_BASE_ADDR + `SENS_CTRL_RADDR);
    localparam logic [15:0] MULT_REG  = 16'(`SENS_BASE_ADDR + `SENS_SYNC_MULT_RADDR);
    localparam logic [15:0] GAMMA_REG = 16'(`SENS_BASE_ADDR + `SENS_GAMMA_RADDR);
    localparam logic [31:0] ADDR_FLAG = 32'd1 << `SENS_GAMMA_ADDR_FLAG_BIT;

    typedef struct packed {
        logic       bit16;
        logic       en;
        logic [7:0] mult;
        logic [7:0] frames;
        logic [7:0] lines;
        logic [7:0] pix;
        logic       reload;                              // rewrite entries 40..43 first
    } row_t;

    logic        mclk = 1'b0;
    logic        mrst;
    logic [7:0]  cmd_ad_i;
    logic        cmd_stb_i;
    logic [11:0] pxd_i;
    logic        hact_i;
    logic        sof_i;
    logic        eof_i;
    logic [15:0] dout_o;
    logic        dout_valid_o;
    logic        sof_o;
    logic        eof_o;
    logic        sof_mclk_o;

    logic [7:0]  gamma [0:255];                          // model copy of the table
    logic [15:0] exp_q [$];                              // expected output words
    logic [15:0] exp_w;
    logic [31:0] rnd;
    logic        exp_sof;                                // this sof_i should pass
    logic        exp_eof;
    logic [3:0]  sof_hist;                               // expected pulses by latency
    logic [3:0]  eof_hist;
    logic        cur_bit16;
    logic        mon_on;
    int          errors;
    int          words_seen;
    int          sofs_seen;
    int          eofs_seen;

    always #2 mclk = ~mclk;                              // 4 ns

    sensor_channel u_sensor_channel (
        .mclk(mclk), .mrst(mrst), .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .pxd_i(pxd_i), .hact_i(hact_i), .sof_i(sof_i), .eof_i(eof_i),
        .dout_o(dout_o), .dout_valid_o(dout_valid_o), .sof_o(sof_o), .eof_o(eof_o),
        .sof_mclk_o(sof_mclk_o)
    );

    function automatic row_t get_row(input int i);
        case (i)       //  b16   en    mult   frm   lines  pix   reload
            0: return '{1'b0, 1'b0, 8'd0, 8'd2, 8'd2, 8'd6,  1'b0}; // disabled after reset
            1: return '{1'b1, 1'b1, 8'd0, 8'd2, 8'd3, 8'd7,  1'b0}; // bypass, odd line
            2: return '{1'b0, 1'b1, 8'd0, 8'd2, 8'd3, 8'd8,  1'b0};
            3: return '{1'b0, 1'b1, 8'd0, 8'd2, 8'd3, 8'd9,  1'b0}; // last pixel dropped
            4: return '{1'b1, 1'b1, 8'd2, 8'd7, 8'd2, 8'd4,  1'b0}; // decimation
            5: return '{1'b0, 1'b1, 8'd1, 8'd5, 8'd2, 8'd5,  1'b0};
            6: return '{1'b0, 1'b0, 8'd0, 8'd2, 8'd2, 8'd6,  1'b0}; // enable cleared
            7: return '{1'b0, 1'b1, 8'd0, 8'd2, 8'd4, 8'd10, 1'b1};
            8: return '{1'b1, 1'b1, 8'd0, 8'd1, 8'd2, 8'd6,  1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int budget_cycles();
        int   cyc;
        row_t r;
        cyc = 8 + 262 * CMD_CYC;                         // reset, table load, reload
        for (int i = 0; i < NROWS; i++) begin
            r = get_row(i);
            cyc += int'(r.frames) * (int'(r.lines) * (int'(r.pix) + 1) + 5);
            cyc += 2 * CMD_CYC + 10;
        end
        return 2 * cyc;
    endfunction

    task automatic tick();
        @(posedge mclk);
        #1;                                              // drive after the edge
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};                            // AL first on the bus
        for (int b = 0; b < `SENS_CMD_BYTES; b++) begin
            cmd_stb_i = (b == 0);
            cmd_ad_i  = bytes[8*b +: 8];
            tick();
        end
        cmd_stb_i = 1'b0;
        tick();                                          // decode cycle
    endtask

    task automatic write_entry(input logic [7:0] idx, input logic [7:0] val);
        send_cmd(GAMMA_REG, {24'd0, val});               // pointer steps in the DUT
        gamma[idx] = val;
    endtask

    task automatic send_line(input row_t r);
        logic [11:0] p;
        logic [7:0]  first;
        first = '0;
        for (int k = 0; k < int'(r.pix); k++) begin
            rnd = xorshift(rnd);
            p   = (r.reload && k[0]) ? {8'h3E + 8'(rnd[2:0]), rnd[6:3]} : rnd[11:0]; // 3e..45
            hact_i = 1'b1;
            pxd_i  = p;
            if (r.en && r.bit16)
                exp_q.push_back({p, 4'h0});
            else if (r.en && k[0])
                exp_q.push_back({gamma[p[11:4]], first}); // earlier pixel low
            first = gamma[p[11:4]];
            tick();
        end
        hact_i = 1'b0;
        tick();                                          // idle between lines
    endtask

    task automatic send_frame(input row_t r, input int f);
        sof_i   = 1'b1;
        exp_sof = r.en && (f % (int'(r.mult) + 1) == 0);
        tick();
        sof_i   = 1'b0;
        exp_sof = 1'b0;
        for (int l = 0; l < int'(r.lines); l++)
            send_line(r);
        eof_i   = 1'b1;
        exp_eof = r.en;
        tick();
        eof_i   = 1'b0;
        exp_eof = 1'b0;
        repeat (3) tick();                               // gap between frames
    endtask

    always @(posedge mclk) begin
        sof_hist <= {sof_hist[2:0], exp_sof};
        eof_hist <= {eof_hist[2:0], exp_eof};
    end

    // output monitor sampled mid-cycle
    always @(negedge mclk) begin
        if (mon_on) begin
            assert (sof_mclk_o === sof_hist[0]) else begin
                $display("** Error: sof_mclk_o = %h, expected %h", sof_mclk_o, sof_hist[0]);
                errors++;
            end
            assert (sof_o === sof_hist[cur_bit16 ? 1 : 3]) else begin
                $display("** Error: sof_o = %h, expected %h", sof_o, sof_hist[cur_bit16 ? 1 : 3]);
                errors++;
            end
            assert (eof_o === eof_hist[cur_bit16 ? 1 : 3]) else begin
                $display("** Error: eof_o = %h, expected %h", eof_o, eof_hist[cur_bit16 ? 1 : 3]);
                errors++;
            end
            if (sof_o === 1'b1)
                sofs_seen++;
            if (eof_o === 1'b1)
                eofs_seen++;
            if (dout_valid_o === 1'b1) begin
                words_seen++;
                assert (exp_q.size() != 0) else begin
                    $display("dout_valid_o pulsed with no word expected, dout_o %h", dout_o);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_w = exp_q.pop_front();
                    assert (dout_o === exp_w) else begin
                        $display("** Error: dout_o = %h, expected %h", dout_o, exp_w);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int limit;
        limit = budget_cycles();
        repeat (limit) @(posedge mclk);
        $display("watchdog expired after %0d cycles, run is stuck", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        row_t r;
        mrst      = 1'b1;
        cmd_ad_i  = '0;
        cmd_stb_i = 1'b0;
        pxd_i     = '0;
        hact_i    = 1'b0;
        sof_i     = 1'b0;
        eof_i     = 1'b0;
        exp_sof   = 1'b0;
        exp_eof   = 1'b0;
        cur_bit16 = 1'b0;
        mon_on    = 1'b0;
        errors    = 0;
        rnd       = 32'h6d14_e48c;
        repeat (8) tick();
        mrst   = 1'b0;
        mon_on = 1'b1;
        send_cmd(GAMMA_REG, ADDR_FLAG);                  // pointer to entry 0
        for (int i = 0; i < 256; i++)
            write_entry(8'(i), 8'(i) ^ 8'hA5);
        for (int i = 0; i < NROWS; i++) begin
            r = get_row(i);
            if (r.reload) begin                          // patch 40..43 only
                send_cmd(GAMMA_REG, ADDR_FLAG | 32'h40);
                for (int j = 0; j < 4; j++)
                    write_entry(8'h40 + 8'(j), 8'hC0 + 8'(j));
            end
            cur_bit16 = r.bit16;
            send_cmd(CTRL_REG, (32'(r.en) << `SENS_MODE_EN_BIT) |
                               (32'(r.bit16) << `SENS_MODE_16BIT_BIT));
            send_cmd(MULT_REG, {24'd0, r.mult});
            repeat (2) tick();                           // let the counter clear
            words_seen = 0;
            sofs_seen  = 0;
            eofs_seen  = 0;
            for (int f = 0; f < int'(r.frames); f++)
                send_frame(r, f);
            repeat (8) tick();                           // drain pipeline
            assert (exp_q.size() == 0) else begin
                $display("row %0d: %0d expected words never came out", i, exp_q.size());
                errors++;
            end
            exp_q.delete();
            $display("row %0d: bit16=%0d en=%0d mult=%0d words=%0d sof=%0d eof=%0d errors=%0d",
                     i, r.bit16, r.en, r.mult, words_seen, sofs_seen, eofs_seen, errors);
        end
        $display("rows run %0d, total errors %0d", NROWS, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/sensor_cmd_pkg.sv
src/sensor_pix_pkg.sv
src/cmd_decoder.sv
src/frame_sync.sv
src/gamma_lut.sv
src/pixel_packer.sv
src/sensor_channel.sv
testbench/tb_sensor_channel.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_sensor_channel
RTL_TOP   ?= sensor_channel
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
